//--- logic/uart_pkg.sv
package uart_pkg;

  localparam int cmd_w = 16;
  localparam int data_w = 8;
  localparam int addr_w = 7;

  // 434 for 115200 baud at 50 MHz
  localparam int bit_cycles = 8;
  localparam int frame_bits = 11;
  localparam int gap_cycles = 16;
  localparam int resp_timeout = 40 * bit_cycles;

  localparam int cyc_w = $clog2(bit_cycles);
  localparam int bits_w = $clog2(frame_bits);
  localparam int wait_w = $clog2(resp_timeout);

  localparam logic [cyc_w-1:0] cyc_last = cyc_w'(bit_cycles - 1);
  localparam logic [cyc_w-1:0] cyc_mid = cyc_w'(bit_cycles / 2 - 1);
  localparam logic [bits_w-1:0] bit_last = bits_w'(frame_bits - 1);
  localparam logic [wait_w-1:0] gap_last = wait_w'(gap_cycles - 1);
  localparam logic [wait_w-1:0] timeout_last = wait_w'(resp_timeout - 1);

  // Sequencer states
  localparam logic [2:0] st_idle = 3'd0;
  localparam logic [2:0] st_addr = 3'd1;
  localparam logic [2:0] st_gap = 3'd2;
  localparam logic [2:0] st_data = 3'd3;
  localparam logic [2:0] st_wait = 3'd4;
  localparam logic [2:0] st_recv = 3'd5;

endpackage

//--- logic/uart_cmd_seq.sv
`timescale 1ns/1ps

module uart_cmd_seq (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [uart_pkg::cmd_w-1:0]  cmd_in,
  input  logic                        cmd_vld,
  input  logic                        tx_done,
  input  logic                        rx_done,
  input  logic [uart_pkg::data_w-1:0] rx_byte,
  input  logic                        rx_bad,
  input  logic                        rx_started,
  output logic                        cmd_rdy,
  output logic                        tx_start,
  output logic [uart_pkg::data_w-1:0] tx_byte,
  output logic                        rx_arm,
  output logic [uart_pkg::data_w-1:0] read_data,
  output logic                        read_rdy,
  output logic                        read_err
);

  logic [2:0]                  state;
  logic [uart_pkg::cmd_w-1:0]  cmd_buf;
  logic [uart_pkg::wait_w-1:0] cnt;
  logic                        frame_out;

  assign cmd_rdy = (state == uart_pkg::st_idle);
  assign rx_arm = (state == uart_pkg::st_wait) || (state == uart_pkg::st_recv);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= uart_pkg::st_idle;
      cnt <= '0;
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      case (state)
        uart_pkg::st_idle:
          if (cmd_vld)
          begin
            tx_start <= 1'b1;
            state <= uart_pkg::st_addr;
          end
        uart_pkg::st_addr:
          if (tx_done)
          begin
            cnt <= '0;
            state <= cmd_buf[uart_pkg::cmd_w-1] ? uart_pkg::st_gap : uart_pkg::st_wait;
          end
        uart_pkg::st_gap:
          if (cnt == uart_pkg::gap_last)
          begin
            tx_start <= 1'b1;
            state <= uart_pkg::st_data;
          end
          else
            cnt <= cnt + 1'b1;
        uart_pkg::st_data:
          if (tx_done)
            state <= uart_pkg::st_idle;
        uart_pkg::st_wait:
          if (rx_started)
            state <= uart_pkg::st_recv;
          else if (cnt == uart_pkg::timeout_last)
          begin
            // Slave never answered
            read_err <= 1'b1;
            state <= uart_pkg::st_idle;
          end
          else
            cnt <= cnt + 1'b1;
        uart_pkg::st_recv:
          if (rx_done)
          begin
            read_rdy <= !rx_bad;
            read_err <= rx_bad;
            state <= uart_pkg::st_idle;
          end
        default:
          state <= uart_pkg::st_idle;
      endcase
    end
  end

  // Address byte is write flag over the 7-bit address
  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
    begin
      cmd_buf <= cmd_in;
      tx_byte <= {cmd_in[uart_pkg::cmd_w-1], cmd_in[uart_pkg::cmd_w-2 -: uart_pkg::addr_w]};
    end
    else if (state == uart_pkg::st_gap && cnt == uart_pkg::gap_last)
      tx_byte <= cmd_buf[uart_pkg::data_w-1:0];
    if (state == uart_pkg::st_recv && rx_done && !rx_bad)
      read_data <= rx_byte;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      frame_out <= 1'b0;
    else if (tx_start)
      frame_out <= 1'b1;
    else if (tx_done)
      frame_out <= 1'b0;
  end

  a_one_result: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |-> !read_err);

  a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !frame_out);

endmodule

//--- logic/uart_frame_tx.sv
`timescale 1ns/1ps

module uart_frame_tx (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        tx_start,
  input  logic [uart_pkg::data_w-1:0] tx_byte,
  output logic                        tx,
  output logic                        tx_done
);

  // Bits still to go after the start bit: data, parity, stop
  logic [uart_pkg::frame_bits-2:0] shreg;
  logic                            busy;
  logic [uart_pkg::cyc_w-1:0]      cyc_cnt;
  logic [uart_pkg::bits_w-1:0]     bit_cnt;
  logic                            bit_end;

  assign bit_end = busy && (cyc_cnt == uart_pkg::cyc_last);
  assign tx_done = bit_end && (bit_cnt == uart_pkg::bit_last);

  always_ff @(posedge clk)
  begin
    if (tx_start)
      shreg <= {1'b1, ^tx_byte, tx_byte};
    else if (bit_end)
      shreg <= {1'b1, shreg[uart_pkg::frame_bits-2:1]};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy <= 1'b0;
      tx <= 1'b1;
      cyc_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (tx_start)
    begin
      busy <= 1'b1;
      tx <= 1'b0;
      cyc_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (busy)
    begin
      if (bit_end)
      begin
        cyc_cnt <= '0;
        if (bit_cnt == uart_pkg::bit_last)
        begin
          busy <= 1'b0;
          tx <= 1'b1;
        end
        else
        begin
          bit_cnt <= bit_cnt + 1'b1;
          tx <= shreg[0];
        end
      end
      else
        cyc_cnt <= cyc_cnt + 1'b1;
    end
  end

  a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> tx);

endmodule

//--- logic/uart_frame_rx.sv
`timescale 1ns/1ps

module uart_frame_rx (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        rx_arm,
  input  logic                        rx,
  output logic                        rx_started,
  output logic                        rx_done,
  output logic [uart_pkg::data_w-1:0] rx_byte,
  output logic                        rx_bad
);

  logic                        rx_s1;
  logic                        rx_s2;
  logic                        rx_q;
  logic                        active;
  logic [uart_pkg::cyc_w-1:0]  cyc_cnt;
  logic [uart_pkg::bits_w-1:0] bit_cnt;
  logic                        sample;
  logic                        par_bit;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_q <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_q <= rx_s2;
    end
  end

  assign sample = active && (cyc_cnt == uart_pkg::cyc_mid);
  assign rx_started = sample && (bit_cnt == '0) && !rx_s2;
  assign rx_done = sample && (bit_cnt == uart_pkg::bit_last);
  // Stop bit is the live sample
  assign rx_bad = (par_bit != ^rx_byte) || !rx_s2;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active <= 1'b0;
      cyc_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (!rx_arm)
      active <= 1'b0;
    else if (!active)
    begin
      if (rx_q && !rx_s2)
      begin
        active <= 1'b1;
        cyc_cnt <= '0;
        bit_cnt <= '0;
      end
    end
    else
    begin
      if (cyc_cnt == uart_pkg::cyc_last)
      begin
        cyc_cnt <= '0;
        bit_cnt <= bit_cnt + 1'b1;
      end
      else
        cyc_cnt <= cyc_cnt + 1'b1;
      // Glitch on the line, not a real start bit
      if ((sample && bit_cnt == '0 && rx_s2) || rx_done)
        active <= 1'b0;
    end
  end

  // LSB arrives first
  always_ff @(posedge clk)
  begin
    if (sample && bit_cnt != '0 && bit_cnt <= uart_pkg::data_w)
      rx_byte <= {rx_s2, rx_byte[uart_pkg::data_w-1:1]};
    if (sample && bit_cnt == uart_pkg::bits_w'(uart_pkg::data_w + 1))
      par_bit <= rx_s2;
  end

  a_done_armed: assert property (@(posedge clk) disable iff (!rst_n)
    rx_done |-> rx_arm);

endmodule

//--- logic/uart_link.sv
`timescale 1ns/1ps

module uart_link (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [uart_pkg::cmd_w-1:0] cmd_in,
  input  logic                       cmd_vld,
  input  logic                       rx,
  output logic                       cmd_rdy,
  output logic                       tx,
  output logic [uart_pkg::data_w-1:0] read_data,
  output logic                       read_rdy,
  output logic                       read_err
);

  logic                        tx_start;
  logic [uart_pkg::data_w-1:0] tx_byte;
  logic                        tx_done;
  logic                        rx_arm;
  logic                        rx_started;
  logic                        rx_done;
  logic [uart_pkg::data_w-1:0] rx_byte;
  logic                        rx_bad;

  uart_cmd_seq i_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .tx_done    (tx_done),
    .rx_done    (rx_done),
    .rx_byte    (rx_byte),
    .rx_bad     (rx_bad),
    .rx_started (rx_started),
    .cmd_rdy    (cmd_rdy),
    .tx_start   (tx_start),
    .tx_byte    (tx_byte),
    .rx_arm     (rx_arm),
    .read_data  (read_data),
    .read_rdy   (read_rdy),
    .read_err   (read_err)
  );

  uart_frame_tx i_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_frame_rx i_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_arm     (rx_arm),
    .rx         (rx),
    .rx_started (rx_started),
    .rx_done    (rx_done),
    .rx_byte    (rx_byte),
    .rx_bad     (rx_bad)
  );

endmodule

//--- testbench/uart_slave_model.sv
`timescale 1ns/1ps

module uart_slave_model (
  input  logic                        clk,
  input  logic                        tx,
  input  logic                        corrupt_parity,
  input  logic                        silent,
  output logic                        rx,
  output logic [uart_pkg::data_w-1:0] log_byte,
  output logic                        log_stb,
  output logic                        frame_bad
);

  logic [uart_pkg::data_w-1:0] regs [0:127];

  // Samples near mid-bit on falling clock edges
  task automatic take_frame(output logic [uart_pkg::data_w-1:0] value, output logic ok);
    logic [uart_pkg::frame_bits-1:0] bits;
    while (tx !== 1'b1)
      @(negedge clk);
    while (tx)
      @(negedge clk);
    repeat (uart_pkg::bit_cycles / 2 - 1)
      @(negedge clk);
    bits[0] = tx;
    for (int i = 1; i < uart_pkg::frame_bits; i++)
    begin
      repeat (uart_pkg::bit_cycles)
        @(negedge clk);
      bits[i] = tx;
    end
    value = bits[8:1];
    ok = !bits[0] && (bits[9] == ^bits[8:1]) && bits[10];
  endtask

  // Returns once the stop bit is on the line
  task automatic send_frame(input logic [uart_pkg::data_w-1:0] value);
    logic [uart_pkg::frame_bits-2:0] bits;
    bits = {(^value) ^ corrupt_parity, value, 1'b0};
    repeat (2 * uart_pkg::bit_cycles)
      @(negedge clk);
    for (int i = 0; i < uart_pkg::frame_bits - 1; i++)
    begin
      @(posedge clk);
      #1;
      rx = bits[i];
      repeat (uart_pkg::bit_cycles - 1)
        @(posedge clk);
    end
    @(posedge clk);
    #1;
    rx = 1'b1;
  endtask

  initial
  begin
    logic [uart_pkg::data_w-1:0] value;
    logic                        ok;
    logic [uart_pkg::addr_w-1:0] wr_addr;
    logic                        wr_pending;
    rx = 1'b1;
    log_byte <= '0;
    log_stb <= 1'b0;
    frame_bad <= 1'b0;
    wr_addr = '0;
    wr_pending = 1'b0;
    for (int a = 0; a < 128; a++)
      regs[a] = 8'(a) ^ 8'h5A;
    forever
    begin
      take_frame(value, ok);
      log_byte <= value;
      log_stb <= 1'b1;
      frame_bad <= !ok;
      @(negedge clk);
      log_stb <= 1'b0;
      frame_bad <= 1'b0;
      if (wr_pending)
      begin
        regs[wr_addr] = value;
        wr_pending = 1'b0;
      end
      else if (value[7])
      begin
        wr_addr = value[6:0];
        wr_pending = 1'b1;
      end
      else if (!silent)
        send_frame(regs[value[6:0]]);
    end
  end

endmodule

//--- testbench/tb_uart_link.sv
`timescale 1ns/1ps

module tb_uart_link;

  localparam int frame_cycles = uart_pkg::frame_bits * uart_pkg::bit_cycles;
  localparam int cmd_limit = 3 * frame_cycles + uart_pkg::resp_timeout;

  logic                        clk;
  logic                        rst_n;
  logic [uart_pkg::cmd_w-1:0]  cmd_in;
  logic                        cmd_vld;
  logic                        rx;
  logic                        cmd_rdy;
  logic                        tx;
  logic [uart_pkg::data_w-1:0] read_data;
  logic                        read_rdy;
  logic                        read_err;
  logic                        corrupt_parity;
  logic                        silent;
  logic [uart_pkg::data_w-1:0] log_byte;
  logic                        log_stb;
  logic                        frame_bad;
  logic [uart_pkg::data_w-1:0] shadow [0:127];
  logic [uart_pkg::data_w-1:0] exp_frames [$];
  // Error flag over the expected byte
  logic [uart_pkg::data_w:0]   exp_reads [$];
  int                          seed;

  uart_link i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_slave_model i_slave (
    .clk            (clk),
    .tx             (tx),
    .corrupt_parity (corrupt_parity),
    .silent         (silent),
    .rx             (rx),
    .log_byte       (log_byte),
    .log_stb        (log_stb),
    .frame_bad      (frame_bad)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #2 clk = ~clk;
  end

  // Address frame byte on top, data frame byte below
  function automatic logic [15:0] encode_cmd(input logic [uart_pkg::cmd_w-1:0] cmd);
    logic [7:0] addr_byte;
    addr_byte = {cmd[15], cmd[14:8]};
    return {addr_byte, cmd[7:0]};
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic fail_value(input string name, input int got, input int want);
    fail_now($sformatf("Fail at %0t ns: %s is 'h%0h, expected 'h%0h",
                       $time, name, got, want));
  endtask

  task automatic wait_cmd_rdy();
    int t;
    t = 0;
    @(negedge clk);
    while (!cmd_rdy)
    begin
      t++;
      assert (t < cmd_limit) else fail_now("Timed out waiting for cmd_rdy");
      @(negedge clk);
    end
  endtask

  task automatic wait_log(input logic check_busy);
    int t;
    t = 0;
    @(negedge clk);
    while (!log_stb)
    begin
      t++;
      assert (t < 2 * frame_cycles) else fail_now("No frame arrived on tx in time");
      if (check_busy)
      begin
        assert (!cmd_rdy) else fail_value("cmd_rdy", cmd_rdy, 0);
      end
      @(negedge clk);
    end
  endtask

  task automatic wait_result(input int limit);
    int t;
    t = 0;
    @(negedge clk);
    while (!read_rdy && !read_err)
    begin
      t++;
      assert (t < limit) else fail_now("Neither read_rdy nor read_err came in time");
      @(negedge clk);
    end
  endtask

  // hold keeps cmd_vld high so the next command waits out the busy period
  task automatic issue_cmd(input logic [15:0] cmd, input logic hold, input logic expect_err);
    logic [15:0] frames;
    @(posedge clk);
    #1;
    cmd_in = cmd;
    cmd_vld = 1'b1;
    wait_cmd_rdy();
    frames = encode_cmd(cmd);
    exp_frames.push_back(frames[15:8]);
    if (cmd[15])
    begin
      exp_frames.push_back(frames[7:0]);
      shadow[cmd[14:8]] = cmd[7:0];
    end
    else
      exp_reads.push_back({expect_err, shadow[cmd[14:8]]});
    @(posedge clk);
    #1;
    if (!hold)
      cmd_vld = 1'b0;
  endtask

  always @(negedge clk)
  begin : compare
    logic [uart_pkg::data_w-1:0] want_byte;
    logic [uart_pkg::data_w:0]   want_read;
    if (rst_n)
    begin
      assert (!(read_rdy && read_err))
        else fail_now("read_rdy and read_err were high together");
      if (log_stb)
      begin
        assert (!frame_bad) else fail_now("Slave model received a malformed frame on tx");
        assert (exp_frames.size() > 0) else fail_now("A frame appeared on tx with no command");
        want_byte = exp_frames.pop_front();
        assert (log_byte == want_byte) else fail_value("tx frame", log_byte, want_byte);
      end
      if (read_rdy || read_err)
      begin
        assert (exp_reads.size() > 0) else fail_now("A read result came with no read command");
        want_read = exp_reads.pop_front();
        assert (read_err == want_read[8]) else fail_value("read_err", read_err, want_read[8]);
        if (!want_read[8])
        begin
          assert (read_data == want_read[7:0])
            else fail_value("read_data", read_data, want_read[7:0]);
        end
      end
    end
  end

  initial
  begin
    logic [15:0] cmd;
    int          gap;
    seed = 32253;
    rst_n = 1'b0;
    cmd_in = '0;
    cmd_vld = 1'b0;
    corrupt_parity = 1'b0;
    silent = 1'b0;
    for (int a = 0; a < 128; a++)
      shadow[a] = 8'(a) ^ 8'h5A;
    repeat (3)
      @(posedge clk);
    #1;
    rst_n = 1'b1;

    @(negedge clk);
    assert (cmd_rdy) else fail_value("cmd_rdy", cmd_rdy, 1);
    assert (!read_rdy) else fail_value("read_rdy", read_rdy, 0);
    assert (!read_err) else fail_value("read_err", read_err, 0);
    repeat (20 * uart_pkg::bit_cycles)
    begin
      @(negedge clk);
      assert (tx) else fail_value("tx", tx, 1);
    end

    // Write 0xC3 to 0x15
    issue_cmd(16'h95C3, 1'b0, 1'b0);
    wait_log(1'b1);
    // Rest of the address frame's stop bit
    repeat (uart_pkg::bit_cycles - uart_pkg::bit_cycles / 2 - 1)
      @(negedge clk);
    gap = 0;
    @(negedge clk);
    while (tx)
    begin
      gap++;
      assert (!cmd_rdy) else fail_value("cmd_rdy", cmd_rdy, 0);
      assert (gap < cmd_limit) else fail_now("No data frame followed the address frame");
      @(negedge clk);
    end
    assert (gap >= uart_pkg::gap_cycles) else fail_value("idle gap", gap, uart_pkg::gap_cycles);
    wait_log(1'b1);
    wait_cmd_rdy();

    issue_cmd(16'h1500, 1'b0, 1'b0);
    wait_result(cmd_limit);
    issue_cmd(16'h6E00, 1'b0, 1'b0);
    wait_result(cmd_limit);

    corrupt_parity = 1'b1;
    issue_cmd(16'h1500, 1'b0, 1'b1);
    wait_result(cmd_limit);
    assert (cmd_rdy) else fail_value("cmd_rdy", cmd_rdy, 1);
    corrupt_parity = 1'b0;

    silent = 1'b1;
    issue_cmd(16'h2A00, 1'b0, 1'b1);
    wait_log(1'b1);
    wait_result(uart_pkg::resp_timeout + frame_cycles);
    assert (cmd_rdy) else fail_value("cmd_rdy", cmd_rdy, 1);
    silent = 1'b0;

    for (int n = 0; n < 40; n++)
    begin
      cmd = 16'($random(seed));
      issue_cmd(cmd, n != 39, 1'b0);
    end
    wait_cmd_rdy();
    @(negedge clk);

    if (exp_frames.size() == 0 && exp_reads.size() == 0)
    begin
      $display("** PASS **");
      $finish;
    end
    else
      fail_now("Some expected frames or read results never arrived");
  end

endmodule

//--- uart_link.f
logic/uart_pkg.sv
logic/uart_cmd_seq.sv
logic/uart_frame_tx.sv
logic/uart_frame_rx.sv
logic/uart_link.sv
testbench/uart_slave_model.sv
testbench/tb_uart_link.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f uart_link.f \
  --top-module tb_uart_link -o sim_uart_link
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit $status
fi

./obj_dir/sim_uart_link
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed"
  exit $status
fi
exit 0
